//--- rtl/sdram_sched_pkg.sv
// SDRAM command scheduler shared geometry, command encoding, request and timing types
package sdram_sched_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = $clog2(NUM_PORTS);
  localparam int BA_W      = 2;
  localparam int NUM_BANKS = 1 << BA_W;
  localparam int ROW_W     = 11;
  localparam int COL_W     = 8;
  localparam int ADDR_W    = 11;
  localparam int AP_BIT    = 10;
  localparam int DQ_W      = 16;
  localparam int DM_W      = DQ_W / 8;

  // Interval and refresh counters
  localparam int TCNT_W    = 6;
  localparam int REF_W     = 16;
  localparam int CL_MAX    = 3;
  localparam int PEND_W    = 3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // CS_n, RAS_n, CAS_n, WE_n
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  typedef struct packed {
    logic             we;
    logic [BA_W-1:0]  ba;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [DQ_W-1:0]  wdata;
    logic [DM_W-1:0]  wmask;
  } sdram_req_t;

  // All intervals in clock cycles
  typedef struct packed {
    logic [REF_W-1:0]  tref;
    logic [TCNT_W-2:0] tras;
    logic [TCNT_W-2:0] trcd;
    logic [TCNT_W-2:0] trp;
    logic [TCNT_W-2:0] twr;
    logic [TCNT_W-2:0] trc;
    logic [TCNT_W-2:0] cl;
  } timing_cfg_t;

  // Column view of the address bus, used on RD, WR and PRE
  typedef struct packed {
    logic                    ap;
    logic [AP_BIT-COL_W-1:0] rsvd;
    logic [COL_W-1:0]        col;
  } sdram_cas_t;

  typedef union packed {
    logic [ADDR_W-1:0] row;
    sdram_cas_t        cas;
  } sdram_addr_u;

  typedef struct packed {
    logic [NUM_BANKS-1:0] open;
    logic [NUM_BANKS-1:0] act_ok;
    logic [NUM_BANKS-1:0] rw_ok;
    logic [NUM_BANKS-1:0] pre_ok;
    logic [NUM_BANKS-1:0] row_hit;
  } bank_ok_t;

  // Interval counters stop at zero
  function automatic logic [TCNT_W-1:0] tmr_dec(input logic [TCNT_W-1:0] cnt);
    return (cnt == '0) ? cnt : cnt - 1'b1;
  endfunction

  // Next command may go out once the count is at or below one
  function automatic logic tmr_done(input logic [TCNT_W-1:0] cnt);
    return cnt <= TCNT_W'(1);
  endfunction

endpackage

//--- rtl/sdram_bank_tracker.sv
// Bank tracker keeps the open row of each bank and its tRAS, tRCD, tRP and tWR intervals
module sdram_bank_tracker
  import sdram_sched_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  timing_cfg_t      cfg_i,
  input  sdram_cmd_e       cmd_i,
  input  logic [BA_W-1:0]  cmd_ba_i,
  input  sdram_addr_u      cmd_addr_i,
  input  logic [BA_W-1:0]  sel_ba_i,
  input  logic [ROW_W-1:0] sel_row_i,
  output bank_ok_t         bank_ok_o
);

  logic [NUM_BANKS-1:0] open_q;
  logic [NUM_BANKS-1:0] open_d;
  logic [ROW_W-1:0]     row_q  [NUM_BANKS];
  logic [ROW_W-1:0]     row_d  [NUM_BANKS];
  logic [TCNT_W-1:0]    tras_q [NUM_BANKS];
  logic [TCNT_W-1:0]    tras_d [NUM_BANKS];
  logic [TCNT_W-1:0]    trcd_q [NUM_BANKS];
  logic [TCNT_W-1:0]    trcd_d [NUM_BANKS];
  logic [TCNT_W-1:0]    trp_q  [NUM_BANKS];
  logic [TCNT_W-1:0]    trp_d  [NUM_BANKS];
  logic [TCNT_W-1:0]    twr_q  [NUM_BANKS];
  logic [TCNT_W-1:0]    twr_d  [NUM_BANKS];
  logic [NUM_BANKS-1:0] act_hit;
  logic [NUM_BANKS-1:0] wr_hit;
  logic [NUM_BANKS-1:0] pre_hit;

  ////////////////////////////////////////////////////////////
  // Next state, including the command now on the bus
  ////////////////////////////////////////////////////////////

  // Outputs look at the next state so the command in flight is already counted
  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      act_hit[b] = (cmd_i == CMD_ACT) && (cmd_ba_i == BA_W'(b));
      wr_hit[b]  = (cmd_i == CMD_WR) && (cmd_ba_i == BA_W'(b));
      pre_hit[b] = (cmd_i == CMD_PRE) && (cmd_addr_i.cas.ap || cmd_ba_i == BA_W'(b));

      open_d[b] = act_hit[b] | (open_q[b] & ~pre_hit[b]);
      row_d[b]  = act_hit[b] ? cmd_addr_i.row : row_q[b];

      tras_d[b] = act_hit[b] ? TCNT_W'(cfg_i.tras) : tmr_dec(tras_q[b]);
      trcd_d[b] = act_hit[b] ? TCNT_W'(cfg_i.trcd) : tmr_dec(trcd_q[b]);
      trp_d[b]  = pre_hit[b] ? TCNT_W'(cfg_i.trp) : tmr_dec(trp_q[b]);
      twr_d[b]  = wr_hit[b] ? TCNT_W'(cfg_i.twr) : tmr_dec(twr_q[b]);
    end
  end

  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      bank_ok_o.open[b]    = open_d[b];
      bank_ok_o.act_ok[b]  = tmr_done(trp_d[b]);
      bank_ok_o.rw_ok[b]   = tmr_done(trcd_d[b]);
      bank_ok_o.pre_ok[b]  = tmr_done(tras_d[b]) && tmr_done(twr_d[b]);
      bank_ok_o.row_hit[b] = open_d[b] && (sel_ba_i == BA_W'(b)) && (row_d[b] == sel_row_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      open_q <= '0;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        tras_q[b] <= '0;
        trcd_q[b] <= '0;
        trp_q[b]  <= '0;
        twr_q[b]  <= '0;
      end
    end
    else
    begin
      open_q <= open_d;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        tras_q[b] <= tras_d[b];
        trcd_q[b] <= trcd_d[b];
        trp_q[b]  <= trp_d[b];
        twr_q[b]  <= twr_d[b];
      end
    end
  end

  // Open row only matters while the bank is open
  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < NUM_BANKS; b++)
      row_q[b] <= row_d[b];
  end

endmodule

//--- rtl/sdram_refresh_ctrl.sv
// Refresh controller counts refresh intervals, pending refreshes and the shared tRC interval
module sdram_refresh_ctrl
  import sdram_sched_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  timing_cfg_t cfg_i,
  input  logic        ref_issue_i,
  input  logic        act_issue_i,
  output logic        ref_pending_o,
  output logic        trc_ok_o
);

  logic [REF_W-1:0]  ref_cnt_q;
  logic              ref_tick;
  logic [PEND_W-1:0] pend_q;
  logic [TCNT_W-1:0] trc_q;

  // One refresh due every tref cycles
  assign ref_tick = (ref_cnt_q == cfg_i.tref - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ref_cnt_q <= '0;
      pend_q    <= '0;
      trc_q     <= '0;
    end
    else
    begin
      ref_cnt_q <= ref_tick ? '0 : ref_cnt_q + 1'b1;

      // Saturates at the pending limit
      case ({ref_tick, ref_issue_i})
        2'b10:   if (pend_q != '1) pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase

      trc_q <= (ref_issue_i || act_issue_i) ? TCNT_W'(cfg_i.trc) : tmr_dec(trc_q);
    end
  end

  assign ref_pending_o = |pend_q;
  assign trc_ok_o      = tmr_done(trc_q);

endmodule

//--- rtl/sdram_cmd_fsm.sv
// Command FSM picks a port and decides one registered SDRAM command per cycle
module sdram_cmd_fsm
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i      [NUM_PORTS],
  input  sdram_req_t        req_data_i [NUM_PORTS],
  input  bank_ok_t          bank_ok_i,
  input  logic              ref_pending_i,
  input  logic              trc_ok_i,
  output logic [BA_W-1:0]   sel_ba_o,
  output logic [ROW_W-1:0]  sel_row_o,
  output logic              ref_issue_o,
  output logic              act_issue_o,
  output logic              rd_issue_o,
  output logic [PORT_W-1:0] rd_port_o,
  output logic              rdy_o      [NUM_PORTS],
  output sdram_cmd_e        sdram_cmd_o,
  output logic [BA_W-1:0]   sdram_ba_o,
  output sdram_addr_u       sdram_addr_o,
  output logic [DQ_W-1:0]   dq_o,
  output logic [DM_W-1:0]   dm_o,
  output logic              dq_oe_o
);

  logic              win_vld;
  logic [PORT_W-1:0] win;
  sdram_req_t        win_req;
  logic [BA_W-1:0]   win_ba;
  sdram_cmd_e        nxt_cmd;
  sdram_addr_u       nxt_addr;
  logic              nxt_rw;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // Lowest port wins; a port is skipped in its rdy cycle
  always_comb
  begin
    win_vld = 1'b0;
    win     = '0;
    for (int p = NUM_PORTS - 1; p >= 0; p--)
    begin
      if (req_i[p] && !rdy_o[p])
      begin
        win_vld = 1'b1;
        win     = PORT_W'(p);
      end
    end
  end

  assign win_req   = req_data_i[win];
  assign win_ba    = win_req.ba;
  assign sel_ba_o  = win_ba;
  assign sel_row_o = win_req.row;

  ////////////////////////////////////////////////////////////
  // Command decision
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    nxt_cmd      = CMD_NOP;
    nxt_addr.row = win_req.row;
    nxt_rw       = 1'b0;

    if (ref_pending_i)
    begin
      // Close everything first, then refresh
      if (|bank_ok_i.open)
      begin
        if (&bank_ok_i.pre_ok)
        begin
          nxt_cmd         = CMD_PRE;
          nxt_addr.cas.ap = 1'b1;
        end
      end
      else if (&bank_ok_i.act_ok && trc_ok_i)
      begin
        nxt_cmd = CMD_REF;
      end
    end
    else if (win_vld)
    begin
      if (bank_ok_i.row_hit[win_ba])
      begin
        if (bank_ok_i.rw_ok[win_ba])
        begin
          nxt_cmd           = win_req.we ? CMD_WR : CMD_RD;
          nxt_addr.cas.ap   = 1'b0;
          nxt_addr.cas.rsvd = '0;
          nxt_addr.cas.col  = win_req.col;
          nxt_rw            = 1'b1;
        end
      end
      else if (!bank_ok_i.open[win_ba])
      begin
        if (bank_ok_i.act_ok[win_ba] && trc_ok_i)
          nxt_cmd = CMD_ACT;
      end
      // Row conflict
      else if (bank_ok_i.pre_ok[win_ba])
      begin
        nxt_cmd         = CMD_PRE;
        nxt_addr.cas.ap = 1'b0;
      end
    end
  end

  assign ref_issue_o = (nxt_cmd == CMD_REF);
  assign act_issue_o = (nxt_cmd == CMD_ACT);
  assign rd_issue_o  = (nxt_cmd == CMD_RD);
  assign rd_port_o   = win;

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sdram_cmd_o <= CMD_NOP;
      dq_oe_o     <= 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
        rdy_o[p] <= 1'b0;
    end
    else
    begin
      sdram_cmd_o <= nxt_cmd;
      dq_oe_o     <= (nxt_cmd == CMD_WR);
      // rdy lines up with RD or WR on the bus
      for (int p = 0; p < NUM_PORTS; p++)
        rdy_o[p] <= nxt_rw && (win == PORT_W'(p));
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= win_ba;
    sdram_addr_o <= nxt_addr;
    dq_o         <= win_req.wdata;
    dm_o         <= win_req.wmask;
  end

endmodule

//--- rtl/sdram_rd_return.sv
// Read return queue delays RD tokens by the CAS latency and routes read data to its port
module sdram_rd_return
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  timing_cfg_t       cfg_i,
  input  logic              rd_issue_i,
  input  logic [PORT_W-1:0] rd_port_i,
  input  logic [DQ_W-1:0]   dq_i,
  output logic              rvalid_o [NUM_PORTS],
  output logic [DQ_W-1:0]   rdata_o
);

  typedef struct packed {
    logic              valid;
    logic [PORT_W-1:0] port;
  } rd_tok_t;

  rd_tok_t                          queue_q [CL_MAX+1];
  logic [$clog2(CL_MAX+1)-1:0]      entry;

  // RD goes on the bus one cycle after issue, so stage cl exits with the data
  assign entry = cfg_i.cl[$clog2(CL_MAX+1)-1:0];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int s = 0; s <= CL_MAX; s++)
        queue_q[s] <= '0;
      for (int p = 0; p < NUM_PORTS; p++)
        rvalid_o[p] <= 1'b0;
    end
    else
    begin
      for (int s = 0; s < CL_MAX; s++)
        queue_q[s] <= queue_q[s+1];
      queue_q[CL_MAX] <= '0;

      if (rd_issue_i)
        queue_q[entry] <= '{valid: 1'b1, port: rd_port_i};

      for (int p = 0; p < NUM_PORTS; p++)
        rvalid_o[p] <= queue_q[0].valid && (queue_q[0].port == PORT_W'(p));
    end
  end

  // Shared by all ports, rvalid says who owns it
  always_ff @(posedge clk_i)
  begin
    if (queue_q[0].valid)
      rdata_o <= dq_i;
  end

endmodule

//--- rtl/sdram_cmd_scheduler.sv
// SDRAM command scheduler top with two fixed-priority ports over a four-bank SDR SDRAM
module sdram_cmd_scheduler
  import sdram_sched_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // Requester ports
  input  logic            req_i      [NUM_PORTS],
  input  sdram_req_t      req_data_i [NUM_PORTS],
  output logic            rdy_o      [NUM_PORTS],
  output logic            rvalid_o   [NUM_PORTS],
  output logic [DQ_W-1:0] rdata_o,

  input  timing_cfg_t     cfg_i,

  // SDRAM bus
  output sdram_cmd_e      sdram_cmd_o,
  output logic [BA_W-1:0] sdram_ba_o,
  output sdram_addr_u     sdram_addr_o,
  output logic [DQ_W-1:0] dq_o,
  output logic [DM_W-1:0] dm_o,
  output logic            dq_oe_o,
  input  logic [DQ_W-1:0] dq_i
);

  bank_ok_t          bank_ok;
  logic [BA_W-1:0]   sel_ba;
  logic [ROW_W-1:0]  sel_row;
  logic              ref_issue;
  logic              act_issue;
  logic              ref_pending;
  logic              trc_ok;
  logic              rd_issue;
  logic [PORT_W-1:0] rd_port;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  sdram_cmd_fsm u_cmd_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .bank_ok_i     (bank_ok),
    .ref_pending_i (ref_pending),
    .trc_ok_i      (trc_ok),
    .sel_ba_o      (sel_ba),
    .sel_row_o     (sel_row),
    .ref_issue_o   (ref_issue),
    .act_issue_o   (act_issue),
    .rd_issue_o    (rd_issue),
    .rd_port_o     (rd_port),
    .rdy_o         (rdy_o),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o),
    .dq_o          (dq_o),
    .dm_o          (dm_o),
    .dq_oe_o       (dq_oe_o)
  );

  // Tracks the command that is on the bus
  sdram_bank_tracker u_bank_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg_i),
    .cmd_i      (sdram_cmd_o),
    .cmd_ba_i   (sdram_ba_o),
    .cmd_addr_i (sdram_addr_o),
    .sel_ba_i   (sel_ba),
    .sel_row_i  (sel_row),
    .bank_ok_o  (bank_ok)
  );

  sdram_refresh_ctrl u_refresh_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg_i),
    .ref_issue_i   (ref_issue),
    .act_issue_i   (act_issue),
    .ref_pending_o (ref_pending),
    .trc_ok_o      (trc_ok)
  );

  sdram_rd_return u_rd_return (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg_i),
    .rd_issue_i (rd_issue),
    .rd_port_i  (rd_port),
    .dq_i       (dq_i),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o)
  );

endmodule

//--- dv/sdram_mem_model.sv
// Behavioral SDRAM that stores written words and returns read data CL cycles after RD
module sdram_mem_model
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic [TCNT_W-2:0] cl_i,
  input  sdram_cmd_e        cmd_i,
  input  logic [BA_W-1:0]   ba_i,
  input  sdram_addr_u       addr_i,
  input  logic [DQ_W-1:0]   dq_i,
  input  logic [DM_W-1:0]   dm_i,
  input  logic              dq_oe_i,
  output logic [DQ_W-1:0]   dq_o
);

  localparam int KEY_W = BA_W + ROW_W + COL_W;

  logic [ROW_W-1:0] row_q [NUM_BANKS];
  logic [DQ_W-1:0]  mem   [logic [KEY_W-1:0]];
  logic [DQ_W-1:0]  pipe  [CL_MAX];

  // Unwritten words read back as a mix of every address bit
  function automatic logic [DQ_W-1:0] fill_word(input logic [KEY_W-1:0] key);
    return key[15:0] ^ {key[20:16], 11'h2a5};
  endfunction

  initial
  begin
    for (int s = 0; s < CL_MAX; s++)
      pipe[s] = '0;
  end

  always @(posedge clk_i)
  begin
    logic [KEY_W-1:0] key;
    logic [DQ_W-1:0]  word;
    key = {ba_i, row_q[ba_i], addr_i.cas.col};
    word = mem.exists(key) ? mem[key] : fill_word(key);
    if (cmd_i == CMD_ACT)
      row_q[ba_i] <= addr_i.row;
    // A set mask bit keeps the old byte
    if (cmd_i == CMD_WR && dq_oe_i)
    begin
      for (int b = 0; b < DM_W; b++)
        if (!dm_i[b])
          word[b*8 +: 8] = dq_i[b*8 +: 8];
      mem[key] = word;
    end
    for (int s = CL_MAX - 1; s > 0; s--)
      pipe[s] <= pipe[s-1];
    pipe[0] <= (cmd_i == CMD_RD) ? word : '0;
  end

  assign dq_o = pipe[int'(cl_i) - 1];

endmodule

//--- dv/tb_sdram_cmd_scheduler.sv
// Testbench for the SDRAM command scheduler with random two-port traffic and protocol checks
module tb_sdram_cmd_scheduler
  import sdram_sched_pkg::*;
();

  localparam int N_REQ   = 60;
  localparam int T_RCD   = 2;
  localparam int T_RAS   = 5;
  localparam int T_RP    = 2;
  localparam int T_WR    = 2;
  localparam int T_RC    = 7;
  localparam int T_CL    = 3;
  localparam int T_REF   = 200;
  localparam int DRAIN   = ((1 << PEND_W) + 1) * T_REF;
  localparam int TIMEOUT = 3000 + 40 * N_REQ * NUM_PORTS;
  localparam int KEY_W   = BA_W + ROW_W + COL_W;

  logic            clk = 1'b0;
  logic            rst_n = 1'b0;
  logic            req      [NUM_PORTS];
  sdram_req_t      req_data [NUM_PORTS];
  logic            rdy      [NUM_PORTS];
  logic            rvalid   [NUM_PORTS];
  logic [DQ_W-1:0] rdata;
  timing_cfg_t     cfg;
  sdram_cmd_e      cmd;
  logic [BA_W-1:0] ba;
  sdram_addr_u     addr;
  logic [DQ_W-1:0] dq_out;
  logic [DM_W-1:0] dm;
  logic            dq_oe;
  logic [DQ_W-1:0] dq_in;

  sdram_req_t      reqs [NUM_PORTS][N_REQ];
  int              gaps [NUM_PORTS][N_REQ];
  int              seed = 32'h1c85;
  int              errors = 0;
  int              cyc;
  int              refs_done;
  int              start    [NUM_PORTS];
  logic            rdy_prev [NUM_PORTS];
  logic            rst_seen = 1'b0;

  // Bus history for the interval rules
  int               last_act [NUM_BANKS];
  int               last_pre [NUM_BANKS];
  int               last_wr  [NUM_BANKS];
  int               last_actref;
  logic             bank_open [NUM_BANKS];
  logic [ROW_W-1:0] bank_row  [NUM_BANKS];

  // Reference memory and the expected read return pipe
  logic [DQ_W-1:0]   ref_mem  [logic [KEY_W-1:0]];
  logic              exp_vld  [T_CL+1];
  logic [PORT_W-1:0] exp_port [T_CL+1];
  logic [DQ_W-1:0]   exp_data [T_CL+1];

  logic rw_ok;
  logic pre_ok;
  logic pre_need;
  logic act_ok;
  logic ref_ok;
  logic idle;
  logic rw_cmd;

  sdram_cmd_scheduler UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .req_data_i   (req_data),
    .rdy_o        (rdy),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .cfg_i        (cfg),
    .sdram_cmd_o  (cmd),
    .sdram_ba_o   (ba),
    .sdram_addr_o (addr),
    .dq_o         (dq_out),
    .dm_o         (dm),
    .dq_oe_o      (dq_oe),
    .dq_i         (dq_in)
  );

  sdram_mem_model u_mem (
    .clk_i   (clk),
    .cl_i    (cfg.cl),
    .cmd_i   (cmd),
    .ba_i    (ba),
    .addr_i  (addr),
    .dq_i    (dq_out),
    .dm_i    (dm),
    .dq_oe_i (dq_oe),
    .dq_o    (dq_in)
  );

  always #10 clk = ~clk;

  function automatic logic [DQ_W-1:0] initial_word(input logic [KEY_W-1:0] key);
    return key[15:0] ^ {key[20:16], 11'h2a5};
  endfunction

  task automatic count_error(input string msg);
    errors = errors + 1;
    $display("%0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus bookkeeping and scoreboard
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc         <= 0;
      refs_done   <= 0;
      last_actref <= -1000;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        last_act[b]  <= -1000;
        last_pre[b]  <= -1000;
        last_wr[b]   <= -1000;
        bank_open[b] <= 1'b0;
      end
      for (int s = 0; s <= T_CL; s++)
        exp_vld[s] <= 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
        rdy_prev[p] <= 1'b0;
    end
    else
    begin
      cyc <= cyc + 1;
      for (int p = 0; p < NUM_PORTS; p++)
        rdy_prev[p] <= rdy[p];
      case (cmd)
        CMD_ACT:
        begin
          last_act[ba]  <= cyc;
          last_actref   <= cyc;
          bank_open[ba] <= 1'b1;
          bank_row[ba]  <= addr.row;
        end
        CMD_PRE:
          for (int b = 0; b < NUM_BANKS; b++)
            if (addr.cas.ap || ba == BA_W'(b))
            begin
              last_pre[b]  <= cyc;
              bank_open[b] <= 1'b0;
            end
        CMD_WR:
          last_wr[ba] <= cyc;
        CMD_REF:
        begin
          last_actref <= cyc;
          refs_done   <= refs_done + 1;
        end
        default: ;
      endcase
      for (int s = 0; s < T_CL; s++)
      begin
        exp_vld[s]  <= exp_vld[s+1];
        exp_port[s] <= exp_port[s+1];
        exp_data[s] <= exp_data[s+1];
      end
      exp_vld[T_CL] <= 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (rdy[p])
        begin
          logic [KEY_W-1:0] key;
          logic [DQ_W-1:0]  word;
          key = {req_data[p].ba, req_data[p].row, req_data[p].col};
          word = ref_mem.exists(key) ? ref_mem[key] : initial_word(key);
          if (req_data[p].we)
          begin
            for (int b = 0; b < DM_W; b++)
              if (!req_data[p].wmask[b])
                word[b*8 +: 8] = req_data[p].wdata[b*8 +: 8];
            ref_mem[key] = word;
          end
          else
          begin
            exp_vld[T_CL]  <= 1'b1;
            exp_port[T_CL] <= PORT_W'(p);
            exp_data[T_CL] <= word;
          end
        end
      end
    end
  end

  always_comb
  begin
    rw_cmd   = (cmd == CMD_RD) || (cmd == CMD_WR);
    rw_ok    = (cyc - last_act[ba] >= T_RCD) && bank_open[ba];
    act_ok   = (cyc - last_pre[ba] >= T_RP) && (cyc - last_actref >= T_RC) && !bank_open[ba];
    ref_ok   = (cyc - last_actref >= T_RC) && (refs_done < cyc / T_REF);
    pre_ok   = 1'b1;
    pre_need = addr.cas.ap && (refs_done < cyc / T_REF);
    idle     = (cmd == CMD_NOP) && !dq_oe;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (addr.cas.ap || ba == BA_W'(b))
        pre_ok = pre_ok && (cyc - last_act[b] >= T_RAS) && (cyc - last_wr[b] >= T_WR);
      ref_ok = ref_ok && !bank_open[b] && (cyc - last_pre[b] >= T_RP);
    end
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      idle = idle && !rdy[p] && !rvalid[p];
      if (!addr.cas.ap && req[p] && req_data[p].ba == ba && bank_open[ba]
          && req_data[p].row != bank_row[ba])
        pre_need = 1'b1;
      if (rdy[p])
        rw_ok = rw_ok && req[p] && rw_cmd && bank_row[ba] == req_data[p].row
                && ba == req_data[p].ba && addr.cas.col == req_data[p].col
                && (cmd == CMD_WR) == req_data[p].we
                && (!req_data[p].we || (dq_out == req_data[p].wdata && dm == req_data[p].wmask));
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk) (!rst_n && rst_seen) |-> idle)
    else count_error("outputs not idle during reset");

  a_first_idle: assert property (@(posedge clk) disable iff (!rst_n) (cyc == 0) |-> idle)
    else count_error("outputs not idle after reset");

  a_oe: assert property (@(posedge clk) disable iff (!rst_n) dq_oe == (cmd == CMD_WR))
    else count_error("dq_oe does not follow WR");

  a_rw: assert property (@(posedge clk) disable iff (!rst_n)
    rw_cmd |-> (rw_ok && (rdy[0] || rdy[1])))
    else count_error("RD or WR breaks tRCD, row or request");

  a_pre: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd == CMD_PRE) |-> (pre_ok && pre_need))
    else count_error("PRE too early or not needed");

  a_act: assert property (@(posedge clk) disable iff (!rst_n) (cmd == CMD_ACT) |-> act_ok)
    else count_error("ACT to open bank or before tRP/tRC");

  a_ref: assert property (@(posedge clk) disable iff (!rst_n) (cmd == CMD_REF) |-> ref_ok)
    else count_error("REF with open bank, early or unneeded");

  a_ref_pace: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc / T_REF - refs_done) <= (1 << PEND_W))
    else count_error("refresh falls behind");

  a_priority: assert property (@(posedge clk) disable iff (!rst_n)
    rdy[1] |-> !(req[0] && start[0] <= start[1]))
    else count_error("port 1 served before port 0");

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port_chk
    a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rdy[p] |-> (rw_cmd && !rdy_prev[p]))
      else count_error($sformatf("bad rdy pulse on port %0d", p));

    a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid[p] == (exp_vld[0] && exp_port[0] == PORT_W'(p)))
      else count_error($sformatf("rvalid wrong on port %0d", p));

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid[p] |-> (rdata == exp_data[0]))
      else
      begin
        errors = errors + 1;
        $display("Mismatch at %0t: port %0d read %h, expected %h", $time, p,
                 $sampled(rdata), $sampled(exp_data[0]));
      end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic play_port(input int p);
    for (int i = 0; i < N_REQ; i++)
    begin
      repeat (gaps[p][i]) @(posedge clk);
      req[p]      <= 1'b1;
      req_data[p] <= reqs[p][i];
      start[p]    <= cyc + 1;
      do
        @(posedge clk);
      while (!rdy[p]);
      req[p] <= 1'b0;
    end
  endtask

  always @(posedge clk)
  begin
    rst_seen <= 1'b1;
    if (rst_n && cyc >= TIMEOUT)
    begin
      $display("Timeout: requests still open after %0d cycles", cyc);
      $display("Errors: %0d", errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    cfg = '{tref: 16'(T_REF), tras: 5'(T_RAS), trcd: 5'(T_RCD), trp: 5'(T_RP),
            twr: 5'(T_WR), trc: 5'(T_RC), cl: 5'(T_CL)};
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p]      = 1'b0;
      req_data[p] = '0;
      start[p]    = 0;
      // Few rows and columns so hits, conflicts and read-backs all occur
      for (int i = 0; i < N_REQ; i++)
      begin
        r = $random(seed);
        reqs[p][i].we    = r[0];
        reqs[p][i].ba    = r[2:1];
        reqs[p][i].row   = ROW_W'(r[4:3]);
        reqs[p][i].col   = COL_W'(r[7:5]);
        reqs[p][i].wmask = (r[9:8] == 2'b00) ? r[11:10] : '0;
        reqs[p][i].wdata = DQ_W'($random(seed));
        gaps[p][i]       = int'(r[13:12]);
      end
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    fork
      play_port(0);
      play_port(1);
    join
    // Idle stretch long enough that missed refreshes would pass the pending limit
    repeat (DRAIN) @(posedge clk);
    $display("Errors: %0d after %0d requests and %0d refreshes",
             errors, N_REQ * NUM_PORTS, refs_done);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- src.f
rtl/sdram_sched_pkg.sv
rtl/sdram_bank_tracker.sv
rtl/sdram_refresh_ctrl.sv
rtl/sdram_cmd_fsm.sv
rtl/sdram_rd_return.sv
rtl/sdram_cmd_scheduler.sv
dv/sdram_mem_model.sv
dv/tb_sdram_cmd_scheduler.sv

//--- run.sh
#!/bin/sh
# Build and run the SDRAM command scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_sdram_cmd_scheduler

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module "$TOP" -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/V"$TOP" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q -F '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0
